//--- design/ls_pkg.sv
package ls_pkg;

    // basic widths
    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int RAM_DEPTH  = 256;
    localparam int RAM_AW     = 8;
    localparam int CSR_AW     = 12;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [ILEN-1:0]   instr_t;
    typedef logic [RAM_AW-1:0] ram_addr_t;
    typedef logic [7:0]        byte_mask_t;
    typedef logic [CSR_AW-1:0] csr_addr_t;

    // major opcodes, bits 6..0 of the instruction
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // memory op, same encoding as funct3 of loads and stores
    // bits 1..0 give the access size, bit 2 marks unsigned loads
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_D  = 3'b011,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101,
        MEM_WU = 3'b110
    } memop_e;

    // csr operation, taken from funct3 bits 1..0
    typedef enum logic [1:0] {
        CSR_NONE = 2'b00,
        CSR_RW   = 2'b01,
        CSR_RS   = 2'b10,
        CSR_RC   = 2'b11
    } csr_op_e;

    // machine csr addresses
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    // store mask patterns before the lane shift
    localparam byte_mask_t MASK_B = 8'b0000_0001;
    localparam byte_mask_t MASK_H = 8'b0000_0011;
    localparam byte_mask_t MASK_W = 8'b0000_1111;
    localparam byte_mask_t MASK_D = 8'b1111_1111;

    // memory request from the decoder to the aligner
    typedef struct packed {
        logic   wren;
        logic   rden;
        memop_e memop;
        xlen_t  addr;
        xlen_t  wr_data;
    } ls_req_t;

    // csr request from the decoder to the csr file
    typedef struct packed {
        csr_op_e   op;
        csr_addr_t addr;
        xlen_t     wdata;
    } csr_req_t;

endpackage

//--- design/ls_decode.sv
`timescale 1ns/1ps

module ls_decode import ls_pkg::*; (
    input  logic     valid_i,
    input  instr_t   instr_i,
    input  instr_t   last_instr_i,
    input  xlen_t    rs2_i,
    input  xlen_t    alures_i,
    input  xlen_t    wb_data_i,
    output ls_req_t  mem_req_o,
    output csr_req_t csr_req_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_load;
    logic       is_store;
    logic       is_system;
    logic       last_is_load;
    logic       fwd_en;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];

    assign is_load   = (opcode == OPC_LOAD);
    assign is_store  = (opcode == OPC_STORE);
    assign is_system = (opcode == OPC_SYSTEM);

    // store rs2 depends on the load just before it
    assign last_is_load = (last_instr_i[6:0] == OPC_LOAD);
    assign fwd_en       = last_is_load && (instr_i[24:20] == last_instr_i[11:7]);

    always_comb begin
        mem_req_o.wren    = valid_i && is_store;
        mem_req_o.rden    = valid_i && is_load;
        mem_req_o.memop   = memop_e'(funct3);
        mem_req_o.addr    = alures_i;
        mem_req_o.wr_data = fwd_en ? wb_data_i : rs2_i;
    end

    // funct3 bits 1..0 select rw, rs or rc; 00 is not a csr access
    always_comb begin
        if (valid_i && is_system) begin
            csr_req_o.op = csr_op_e'(funct3[1:0]);
        end else begin
            csr_req_o.op = CSR_NONE;
        end
        csr_req_o.addr  = instr_i[31:20];
        csr_req_o.wdata = alures_i;
    end

endmodule

//--- design/lsu_align.sv
`timescale 1ns/1ps

module lsu_align import ls_pkg::*; (
    input  ls_req_t    mem_req_i,
    input  xlen_t      rd_word_i,
    output logic       ram_we_o,
    output ram_addr_t  ram_idx_o,
    output byte_mask_t ram_mask_o,
    output xlen_t      ram_wdata_o,
    output xlen_t      ls_res_o
);

    logic [1:0] size;
    logic [2:0] byte_off;
    byte_mask_t base_mask;
    xlen_t      lane_word;
    xlen_t      wdata;

    // access size lives in the low two bits of memop
    assign size  = mem_req_i.memop[1:0];
    assign wdata = mem_req_i.wr_data;

    // offset with the bits below the access size dropped
    always_comb begin
        case (size)
            2'b00:   byte_off = mem_req_i.addr[2:0];
            2'b01:   byte_off = {mem_req_i.addr[2:1], 1'b0};
            2'b10:   byte_off = {mem_req_i.addr[2], 2'b00};
            default: byte_off = 3'b000;
        endcase
    end

    always_comb begin
        case (size)
            2'b00:   base_mask = MASK_B;
            2'b01:   base_mask = MASK_H;
            2'b10:   base_mask = MASK_W;
            default: base_mask = MASK_D;
        endcase
    end

    assign ram_we_o   = mem_req_i.wren;
    assign ram_idx_o  = mem_req_i.addr[10:3];
    assign ram_mask_o = base_mask << byte_off;

    // store data replicated across all lanes, the mask picks the right one
    always_comb begin
        case (size)
            2'b00:   ram_wdata_o = {8{wdata[7:0]}};
            2'b01:   ram_wdata_o = {4{wdata[15:0]}};
            2'b10:   ram_wdata_o = {2{wdata[31:0]}};
            default: ram_wdata_o = wdata;
        endcase
    end

    // move the addressed lane down to bit 0
    assign lane_word = rd_word_i >> {byte_off, 3'b000};

    always_comb begin
        ls_res_o = '0;
        if (mem_req_i.rden) begin
            case (mem_req_i.memop)
                MEM_B: begin
                    ls_res_o = {{56{lane_word[7]}}, lane_word[7:0]};
                end
                MEM_H: begin
                    ls_res_o = {{48{lane_word[15]}}, lane_word[15:0]};
                end
                MEM_W: begin
                    ls_res_o = {{32{lane_word[31]}}, lane_word[31:0]};
                end
                MEM_D: begin
                    ls_res_o = lane_word;
                end
                MEM_BU: begin
                    ls_res_o = {56'b0, lane_word[7:0]};
                end
                MEM_HU: begin
                    ls_res_o = {48'b0, lane_word[15:0]};
                end
                MEM_WU: begin
                    ls_res_o = {32'b0, lane_word[31:0]};
                end
                default: begin
                    // funct3 111 is no valid load
                    ls_res_o = '0;
                end
            endcase
        end
    end

endmodule

//--- design/data_ram.sv
`timescale 1ns/1ps

module data_ram import ls_pkg::*; (
    input  logic       clk,
    input  logic       we_i,
    input  ram_addr_t  idx_i,
    input  byte_mask_t mask_i,
    input  xlen_t      wdata_i,
    output xlen_t      rdata_o
);

    xlen_t mem [RAM_DEPTH];

    // byte-masked write at the rising edge
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int i = 0; i < 8; i++) begin
                if (mask_i[i]) begin
                    mem[idx_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
                end
            end
        end
    end

    // asynchronous read, a load sees the contents before this edge
    assign rdata_o = mem[idx_i];

endmodule

//--- design/csr_file.sv
`timescale 1ns/1ps

module csr_file import ls_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  csr_req_t csr_req_i,
    input  logic     trap_i,
    input  xlen_t    pc_i,
    input  xlen_t    trap_cause_i,
    output xlen_t    csr_data_o,
    output xlen_t    mtvec_o,
    output xlen_t    mepc_o
);

    xlen_t mtvec_q;
    xlen_t mepc_q;
    xlen_t mcause_q;
    xlen_t mscratch_q;

    xlen_t old_val;
    xlen_t new_val;
    logic  hit;
    logic  csr_wr;

    // read mux for the addressed register
    always_comb begin
        hit     = 1'b1;
        old_val = '0;
        case (csr_req_i.addr)
            CSR_MTVEC:    old_val = mtvec_q;
            CSR_MEPC:     old_val = mepc_q;
            CSR_MCAUSE:   old_val = mcause_q;
            CSR_MSCRATCH: old_val = mscratch_q;
            default:      hit = 1'b0;
        endcase
    end

    // read-modify-write value
    always_comb begin
        case (csr_req_i.op)
            CSR_RW:  new_val = csr_req_i.wdata;
            CSR_RS:  new_val = old_val | csr_req_i.wdata;
            CSR_RC:  new_val = old_val & ~csr_req_i.wdata;
            default: new_val = old_val;
        endcase
    end

    assign csr_wr = (csr_req_i.op != CSR_NONE) && hit;

    // old value out, zero for no op or unknown address
    assign csr_data_o = csr_wr ? old_val : '0;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mscratch_q <= '0;
        end else begin
            if (csr_wr && csr_req_i.addr == CSR_MTVEC) begin
                mtvec_q <= new_val;
            end
            if (csr_wr && csr_req_i.addr == CSR_MSCRATCH) begin
                mscratch_q <= new_val;
            end
            // trap capture beats a csr write to the same register
            if (trap_i) begin
                mepc_q   <= pc_i;
                mcause_q <= trap_cause_i;
            end else begin
                if (csr_wr && csr_req_i.addr == CSR_MEPC) begin
                    mepc_q <= new_val;
                end
                if (csr_wr && csr_req_i.addr == CSR_MCAUSE) begin
                    mcause_q <= new_val;
                end
            end
        end
    end

    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;

endmodule

//--- design/ls_stage.sv
`timescale 1ns/1ps

module ls_stage import ls_pkg::*; (
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   valid_i,
    input  instr_t instr_i,
    input  xlen_t  pc_i,
    input  xlen_t  alures_i,
    input  xlen_t  rs2_i,
    input  xlen_t  wb_data_i,
    input  logic   trap_i,
    input  xlen_t  trap_cause_i,
    output xlen_t  ls_res_o,
    output xlen_t  csr_data_o,
    output xlen_t  mtvec_o,
    output xlen_t  mepc_o
);

    instr_t     last_instr;
    ls_req_t    mem_req;
    csr_req_t   csr_req;
    logic       ram_we;
    ram_addr_t  ram_idx;
    byte_mask_t ram_mask;
    xlen_t      ram_wdata;
    xlen_t      ram_rdata;

    // last valid instruction, used for load-to-store forwarding
    // all zero after reset, which is not a load
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_instr <= '0;
        end else if (valid_i) begin
            last_instr <= instr_i;
        end
    end

    ls_decode u_decode (
        .valid_i      (valid_i),
        .instr_i      (instr_i),
        .last_instr_i (last_instr),
        .rs2_i        (rs2_i),
        .alures_i     (alures_i),
        .wb_data_i    (wb_data_i),
        .mem_req_o    (mem_req),
        .csr_req_o    (csr_req)
    );

    lsu_align u_align (
        .mem_req_i   (mem_req),
        .rd_word_i   (ram_rdata),
        .ram_we_o    (ram_we),
        .ram_idx_o   (ram_idx),
        .ram_mask_o  (ram_mask),
        .ram_wdata_o (ram_wdata),
        .ls_res_o    (ls_res_o)
    );

    data_ram u_ram (
        .clk     (clk),
        .we_i    (ram_we),
        .idx_i   (ram_idx),
        .mask_i  (ram_mask),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    csr_file u_csr (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .csr_req_i    (csr_req),
        .trap_i       (trap_i),
        .pc_i         (pc_i),
        .trap_cause_i (trap_cause_i),
        .csr_data_o   (csr_data_o),
        .mtvec_o      (mtvec_o),
        .mepc_o       (mepc_o)
    );

endmodule

//--- dv/tb_ls_stage.sv
`timescale 1ns/1ps

module tb_ls_stage import ls_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int CLK_HALF   = 10;
    localparam int N_RAND     = 12;

    // one row of the directed table
    typedef struct packed {
        logic   valid;
        instr_t instr;
        xlen_t  alures;
        xlen_t  rs2;
        xlen_t  wb_data;
        logic   trap;
        xlen_t  pc;
        xlen_t  cause;
        xlen_t  exp_ls;
        xlen_t  exp_csr;
        xlen_t  exp_mtvec;
        xlen_t  exp_mepc;
    } entry_t;

    logic   clk;
    logic   rst_n_i;
    logic   valid_i;
    instr_t instr_i;
    xlen_t  pc_i;
    xlen_t  alures_i;
    xlen_t  rs2_i;
    xlen_t  wb_data_i;
    logic   trap_i;
    xlen_t  trap_cause_i;
    xlen_t  ls_res_o;
    xlen_t  csr_data_o;
    xlen_t  mtvec_o;
    xlen_t  mepc_o;

    entry_t      table_q[$];
    logic [7:0]  ref_mem [2048];
    logic [31:0] lcg_state;
    int          checks;
    int          errors;
    int          budget_ns;

    ls_stage dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .alures_i     (alures_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .trap_i       (trap_i),
        .trap_cause_i (trap_cause_i),
        .ls_res_o     (ls_res_o),
        .csr_data_o   (csr_data_o),
        .mtvec_o      (mtvec_o),
        .mepc_o       (mepc_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    function automatic instr_t enc_ld(input logic [4:0] rd, input logic [2:0] f3);
        return {12'h000, 5'd0, f3, rd, OPC_LOAD};
    endfunction

    function automatic instr_t enc_st(input logic [4:0] rs2, input logic [2:0] f3);
        return {7'd0, rs2, 5'd0, f3, 5'd0, OPC_STORE};
    endfunction

    function automatic instr_t enc_csr(input logic [2:0] f3, input csr_addr_t csr);
        return {csr, 5'd0, f3, 5'd0, OPC_SYSTEM};
    endfunction

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // low address bits below the access size do not count
    function automatic logic [2:0] lane_offset(input xlen_t addr, input logic [1:0] sz);
        return addr[2:0] & ~3'((1 << sz) - 1);
    endfunction

    function automatic void model_store(input xlen_t addr, input logic [1:0] sz,
                                        input xlen_t data);
        logic [10:0] base;
        base = {addr[10:3], lane_offset(addr, sz)};
        for (int i = 0; i < (1 << sz); i++) begin
            ref_mem[base + 11'(i)] = data[8*i +: 8];
        end
    endfunction

    function automatic xlen_t model_load(input xlen_t addr, input logic [2:0] f3);
        xlen_t       val;
        logic [10:0] base;
        int          nbytes;
        int          sh;
        nbytes = 1 << f3[1:0];
        base   = {addr[10:3], lane_offset(addr, f3[1:0])};
        val    = '0;
        for (int i = 0; i < nbytes; i++) begin
            val[8*i +: 8] = ref_mem[base + 11'(i)];
        end
        // funct3 bit 2 clear means sign extension
        if (!f3[2] && nbytes < 8) begin
            sh  = 64 - 8 * nbytes;
            val = $signed(val << sh) >>> sh;
        end
        return val;
    endfunction

    task automatic compare_value(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic add_entry(input logic v, input instr_t ins, input xlen_t alu,
                             input xlen_t rs2, input xlen_t wb, input logic trap,
                             input xlen_t pc, input xlen_t cause, input xlen_t e_ls,
                             input xlen_t e_csr, input xlen_t e_mtvec, input xlen_t e_mepc);
        table_q.push_back('{v, ins, alu, rs2, wb, trap, pc, cause,
                            e_ls, e_csr, e_mtvec, e_mepc});
    endtask

    // drive on the falling edge and return just before the next rising edge
    task automatic drive_cycle(input logic v, input instr_t ins, input xlen_t alu,
                               input xlen_t rs2, input xlen_t wb, input logic trap,
                               input xlen_t pc, input xlen_t cause);
        @(negedge clk);
        valid_i      = v;
        instr_i      = ins;
        alures_i     = alu;
        rs2_i        = rs2;
        wb_data_i    = wb;
        trap_i       = trap;
        pc_i         = pc;
        trap_cause_i = cause;
        #(CLK_HALF - 1);
    endtask

    task automatic build_table();
        // full word and partial stores
        add_entry(1'b1, enc_st(5'd6, MEM_D), 64'h100, 64'h1122334455667788, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_ld(5'd5, MEM_D), 64'h100, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h1122334455667788, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_st(5'd6, MEM_B), 64'h105, 64'h99887766554433aa, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_st(5'd6, MEM_H), 64'h106, 64'h555544443333beef, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_st(5'd6, MEM_W), 64'h100, 64'h12345678cafef00d, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_ld(5'd5, MEM_D), 64'h100, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'hbeefaa44cafef00d, 64'h0, 64'h0, 64'h0);
        // lanes and extension
        add_entry(1'b1, enc_st(5'd6, MEM_D), 64'h108, 64'hf0e1d2c3b4a59687, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_ld(5'd5, MEM_B), 64'h108, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'hffffffffffffff87, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_ld(5'd5, MEM_BU), 64'h10d, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h00000000000000d2, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_ld(5'd5, MEM_H), 64'h10b, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'hffffffffffffb4a5, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_ld(5'd5, MEM_HU), 64'h10e, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h000000000000f0e1, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_ld(5'd5, MEM_W), 64'h10c, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'hfffffffff0e1d2c3, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_ld(5'd5, MEM_WU), 64'h10f, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h00000000f0e1d2c3, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_ld(5'd5, MEM_W), 64'h108, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'hffffffffb4a59687, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_ld(5'd5, MEM_D), 64'h10b, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'hf0e1d2c3b4a59687, 64'h0, 64'h0, 64'h0);
        // load then dependent store through x7
        add_entry(1'b1, enc_st(5'd6, MEM_D), 64'h110, 64'h0, 64'h77,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_ld(5'd7, MEM_D), 64'h110, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_st(5'd7, MEM_D), 64'h118, 64'h1111, 64'h2222333344445555,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_ld(5'd5, MEM_D), 64'h118, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h2222333344445555, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_st(5'd7, MEM_D), 64'h118, 64'h0123456789abcdef, 64'hdead,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_ld(5'd5, MEM_D), 64'h118, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0123456789abcdef, 64'h0, 64'h0, 64'h0);
        // csr read-modify-write
        add_entry(1'b1, enc_csr({1'b0, CSR_RW}, CSR_MSCRATCH), 64'h5a5a, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_csr({1'b0, CSR_RW}, CSR_MTVEC), 64'h80000100, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h0);
        add_entry(1'b1, enc_csr({1'b0, CSR_RS}, CSR_MTVEC), 64'h0f, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h80000100, 64'h80000100, 64'h0);
        add_entry(1'b1, enc_csr({1'b0, CSR_RC}, CSR_MTVEC), 64'h103, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h8000010f, 64'h8000010f, 64'h0);
        add_entry(1'b1, enc_csr({1'b0, CSR_RW}, 12'h7c0), 64'h1234, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h8000000c, 64'h0);
        add_entry(1'b1, enc_csr({1'b0, CSR_RS}, CSR_MSCRATCH), 64'h0, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h5a5a, 64'h8000000c, 64'h0);
        // trap capture and then a trap against a csr write to mepc
        add_entry(1'b1, 32'h00000013, 64'h0, 64'h0, 64'h0,
                  1'b1, 64'h4000, 64'h0b, 64'h0, 64'h0, 64'h8000000c, 64'h0);
        add_entry(1'b1, enc_csr({1'b0, CSR_RS}, CSR_MCAUSE), 64'h0, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h0b, 64'h8000000c, 64'h4000);
        add_entry(1'b1, enc_csr({1'b0, CSR_RW}, CSR_MEPC), 64'h9999, 64'h0, 64'h0,
                  1'b1, 64'h5000, 64'h02, 64'h0, 64'h4000, 64'h8000000c, 64'h4000);
        add_entry(1'b1, enc_csr({1'b0, CSR_RS}, CSR_MEPC), 64'h0, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h5000, 64'h8000000c, 64'h5000);
        add_entry(1'b1, enc_csr({1'b0, CSR_RS}, CSR_MCAUSE), 64'h0, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h02, 64'h8000000c, 64'h5000);
        // valid low must leave ram and csrs alone
        add_entry(1'b0, enc_st(5'd6, MEM_D), 64'h100, 64'hffffffffffffffff, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h8000000c, 64'h5000);
        add_entry(1'b0, enc_csr({1'b0, CSR_RW}, CSR_MTVEC), 64'hffff, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h8000000c, 64'h5000);
        add_entry(1'b0, enc_ld(5'd5, MEM_D), 64'h100, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h0, 64'h8000000c, 64'h5000);
        add_entry(1'b1, enc_ld(5'd5, MEM_D), 64'h100, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'hbeefaa44cafef00d, 64'h0, 64'h8000000c, 64'h5000);
        add_entry(1'b1, enc_csr({1'b0, CSR_RS}, CSR_MTVEC), 64'h0, 64'h0, 64'h0,
                  1'b0, 64'h0, 64'h0, 64'h0, 64'h8000000c, 64'h8000000c, 64'h5000);
    endtask

    // random store followed by a load of the same size at the same address
    task automatic run_random_pair(input int n);
        xlen_t       addr;
        xlen_t       data;
        xlen_t       wb;
        logic [31:0] rnd;
        logic [2:0]  ld_f3;
        int          errs_before;
        addr = {next_rand(), next_rand()};
        data = {next_rand(), next_rand()};
        wb   = {next_rand(), next_rand()};
        rnd  = next_rand();
        errs_before = errors;
        drive_cycle(1'b1, enc_st(5'd6, {1'b0, rnd[1:0]}), addr, data, wb, 1'b0, 64'h0, 64'h0);
        model_store(addr, rnd[1:0], data);
        compare_value("ls_res_o", ls_res_o, 64'h0);
        // a double has no unsigned form
        ld_f3 = (rnd[1:0] == 2'b11) ? 3'b011 : {rnd[2], rnd[1:0]};
        drive_cycle(1'b1, enc_ld(5'd5, ld_f3), addr, wb, data, 1'b0, 64'h0, 64'h0);
        compare_value("ls_res_o", ls_res_o, model_load(addr, ld_f3));
        compare_value("csr_data_o", csr_data_o, 64'h0);
        if (errors == errs_before) begin
            $display("random pair %0d ok", n);
        end else begin
            $display("random pair %0d error", n);
        end
    endtask

    initial begin
        entry_t e;
        int     errs_before;
        rst_n_i      = 1'b0;
        valid_i      = 1'b0;
        instr_i      = '0;
        pc_i         = '0;
        alures_i     = '0;
        rs2_i        = '0;
        wb_data_i    = '0;
        trap_i       = 1'b0;
        trap_cause_i = '0;
        checks       = 0;
        errors       = 0;
        lcg_state    = 32'hbf5d9534;
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        for (int i = 0; i < table_q.size(); i++) begin
            e = table_q[i];
            errs_before = errors;
            drive_cycle(e.valid, e.instr, e.alures, e.rs2, e.wb_data, e.trap, e.pc, e.cause);
            compare_value("ls_res_o", ls_res_o, e.exp_ls);
            compare_value("csr_data_o", csr_data_o, e.exp_csr);
            compare_value("mtvec_o", mtvec_o, e.exp_mtvec);
            compare_value("mepc_o", mepc_o, e.exp_mepc);
            if (errors == errs_before) begin
                $display("table entry %0d ok", i);
            end else begin
                $display("table entry %0d error", i);
            end
        end
        for (int n = 0; n < N_RAND; n++) begin
            run_random_pair(n);
        end
        $display("tests %0d checks %0d errors %0d", table_q.size() + N_RAND, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog sized from the table, the random pairs and reset
    initial begin
        #1;
        budget_ns = (table_q.size() + N_RAND * 2 + 16) * CLK_PERIOD * 2;
        #(budget_ns);
        $display("watchdog expired before all tests completed");
        $display("Test failed");
        $finish;
    end

endmodule

//--- build.f
design/ls_pkg.sv
design/ls_decode.sv
design/lsu_align.sv
design/data_ram.sv
design/csr_file.sv
design/ls_stage.sv
dv/tb_ls_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ls_stage testbench with verilator
rm -f sim.log
verilator --binary --timing --top-module tb_ls_stage -f build.f -o sim_ls_stage \
    && ./obj_dir/sim_ls_stage > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }
